// ==== source/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address and data bus widths.
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// one strobe bit per data byte.
`define MEM_STRB_W 4

// memory size in words.
`define MEM_DEPTH 256

// nonzero start value of the stall lfsr.
`define MEM_LFSR_SEED 20'h5A3C1

// 1 lets the lfsr stall the slave, 0 keeps it ready.
`define MEM_STALL_EN 1

`endif

// ==== source/bus_pkg.sv ====
`include "mem_consts.svh"

package bus_pkg;

  // response codes as on axi-lite.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // read address channel.
  typedef struct packed {
    logic                   valid;
    logic [`MEM_ADDR_W-1:0] addr;
  } ar_req_t;

  // read data channel.
  typedef struct packed {
    logic                   valid;
    logic [`MEM_DATA_W-1:0] data;
    resp_e                  resp;
  } r_resp_t;

  // address and data travel together on writes.
  typedef struct packed {
    logic                   valid;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
    logic [`MEM_STRB_W-1:0] strb;
  } w_req_t;

  // write response channel.
  typedef struct packed {
    logic  valid;
    resp_e resp;
  } b_resp_t;

endpackage

// ==== source/arb_pkg.sv ====
package arb_pkg;

  // arbiter fsm states.
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IFU_RD,
    ARB_LSU_RD,
    ARB_LSU_WR
  } arb_state_e;

  // channel that currently owns the slave.
  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_IFU_RD,
    GNT_LSU_RD,
    GNT_LSU_WR
  } grant_e;

endpackage

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            ifu_ar_valid_i,
  input  logic            lsu_ar_valid_i,
  input  logic            lsu_w_valid_i,
  input  logic            resp_done_i,
  output arb_pkg::grant_e grant_o
);
  import arb_pkg::*;

  arb_state_e state_q;
  arb_state_e state_d;
  logic       last_lsu_q;
  logic       last_lsu_d;
  logic       lsu_req;
  logic       ifu_wins;

  assign lsu_req = lsu_ar_valid_i | lsu_w_valid_i;

  // on a conflict the master not served last goes first.
  assign ifu_wins = ifu_ar_valid_i & (~lsu_req | last_lsu_q);

  always_comb begin
    state_d    = state_q;
    last_lsu_d = last_lsu_q;
    case (state_q)
      ARB_IDLE: begin
        if (ifu_wins) begin
          state_d    = ARB_IFU_RD;
          last_lsu_d = 1'b0;
        end else if (lsu_w_valid_i) begin
          // stores ahead of loads.
          state_d    = ARB_LSU_WR;
          last_lsu_d = 1'b1;
        end else if (lsu_ar_valid_i) begin
          state_d    = ARB_LSU_RD;
          last_lsu_d = 1'b1;
        end
      end
      ARB_IFU_RD,
      ARB_LSU_RD,
      ARB_LSU_WR: begin
        // grant is held until the response is taken.
        if (resp_done_i) begin
          state_d = ARB_IDLE;
        end
      end
      default: begin
        state_d = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= ARB_IDLE;
      last_lsu_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      last_lsu_q <= last_lsu_d;
    end
  end

  // grant follows the state register.
  always_comb begin
    case (state_q)
      ARB_IFU_RD: begin
        grant_o = GNT_IFU_RD;
      end
      ARB_LSU_RD: begin
        grant_o = GNT_LSU_RD;
      end
      ARB_LSU_WR: begin
        grant_o = GNT_LSU_WR;
      end
      default: begin
        grant_o = GNT_NONE;
      end
    endcase
  end

endmodule

// ==== source/bus_mux.sv ====
`timescale 1ns/1ps

module bus_mux (
  input  arb_pkg::grant_e  grant_i,
  input  bus_pkg::ar_req_t ifu_ar_i,
  input  bus_pkg::ar_req_t lsu_ar_i,
  input  bus_pkg::w_req_t  lsu_w_i,
  input  logic             ifu_r_ready_i,
  input  logic             lsu_r_ready_i,
  input  logic             lsu_b_ready_i,
  output logic             ifu_ar_ready_o,
  output logic             lsu_ar_ready_o,
  output logic             lsu_w_ready_o,
  output bus_pkg::r_resp_t ifu_r_o,
  output bus_pkg::r_resp_t lsu_r_o,
  output bus_pkg::b_resp_t lsu_b_o,
  output bus_pkg::ar_req_t slv_ar_o,
  output bus_pkg::w_req_t  slv_w_o,
  input  logic             slv_ar_ready_i,
  input  logic             slv_w_ready_i,
  input  bus_pkg::r_resp_t slv_r_i,
  input  bus_pkg::b_resp_t slv_b_i,
  output logic             slv_r_ready_o,
  output logic             slv_b_ready_o,
  output logic             resp_done_o
);
  import arb_pkg::*;
  import bus_pkg::*;

  always_comb begin
    // ungranted channels stay quiet.
    slv_ar_o       = '0;
    slv_w_o        = '0;
    slv_r_ready_o  = 1'b0;
    slv_b_ready_o  = 1'b0;
    ifu_ar_ready_o = 1'b0;
    lsu_ar_ready_o = 1'b0;
    lsu_w_ready_o  = 1'b0;
    ifu_r_o        = '0;
    lsu_r_o        = '0;
    lsu_b_o        = '0;
    resp_done_o    = 1'b0;
    case (grant_i)
      GNT_IFU_RD: begin
        slv_ar_o       = ifu_ar_i;
        ifu_ar_ready_o = slv_ar_ready_i;
        ifu_r_o        = slv_r_i;
        slv_r_ready_o  = ifu_r_ready_i;
        resp_done_o    = slv_r_i.valid & ifu_r_ready_i;
      end
      GNT_LSU_RD: begin
        slv_ar_o       = lsu_ar_i;
        lsu_ar_ready_o = slv_ar_ready_i;
        lsu_r_o        = slv_r_i;
        slv_r_ready_o  = lsu_r_ready_i;
        resp_done_o    = slv_r_i.valid & lsu_r_ready_i;
      end
      GNT_LSU_WR: begin
        slv_w_o       = lsu_w_i;
        lsu_w_ready_o = slv_w_ready_i;
        lsu_b_o       = slv_b_i;
        slv_b_ready_o = lsu_b_ready_i;
        resp_done_o   = slv_b_i.valid & lsu_b_ready_i;
      end
      default: begin
        resp_done_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/sram_slave.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module sram_slave (
  input  logic             clk,
  input  logic             rst_n_i,
  input  bus_pkg::ar_req_t ar_i,
  output logic             ar_ready_o,
  output bus_pkg::r_resp_t r_o,
  input  logic             r_ready_i,
  input  bus_pkg::w_req_t  w_i,
  output logic             w_ready_o,
  output bus_pkg::b_resp_t b_o,
  input  logic             b_ready_i
);
  import bus_pkg::*;

  localparam int OFS_W  = $clog2(`MEM_STRB_W);
  localparam int WORD_W = `MEM_ADDR_W - OFS_W;
  localparam int IDX_W  = $clog2(`MEM_DEPTH);
  localparam logic [WORD_W-1:0] DEPTH = WORD_W'(`MEM_DEPTH);

  logic [`MEM_DATA_W-1:0] mem_q [`MEM_DEPTH];
  logic [19:0]            lfsr_q;
  logic                   not_stalled;
  logic                   idle;
  logic                   ar_fire;
  logic                   w_fire;
  logic [WORD_W-1:0]      rd_word;
  logic [WORD_W-1:0]      wr_word;
  logic                   rd_in_range;
  logic                   wr_in_range;
  logic                   r_valid_q;
  logic [`MEM_DATA_W-1:0] r_data_q;
  resp_e                  r_resp_q;
  logic                   b_valid_q;
  resp_e                  b_resp_q;

  // x^20 + x^17 + 1.
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lfsr_q <= `MEM_LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  assign not_stalled = (`MEM_STALL_EN != 0) ? lfsr_q[19] : 1'b1;
  assign idle        = ~r_valid_q & ~b_valid_q;

  // reads win if both show up at once.
  assign ar_ready_o = not_stalled & idle;
  assign w_ready_o  = not_stalled & idle & ~ar_i.valid;
  assign ar_fire    = ar_i.valid & ar_ready_o;
  assign w_fire     = w_i.valid & w_ready_o;

  assign rd_word     = ar_i.addr[`MEM_ADDR_W-1:OFS_W];
  assign wr_word     = w_i.addr[`MEM_ADDR_W-1:OFS_W];
  assign rd_in_range = rd_word < DEPTH;
  assign wr_in_range = wr_word < DEPTH;

  always_ff @(posedge clk) begin
    if (w_fire && wr_in_range) begin
      for (int i = 0; i < `MEM_STRB_W; i++) begin
        if (w_i.strb[i]) begin
          mem_q[wr_word[IDX_W-1:0]][8*i +: 8] <= w_i.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      r_data_q <= rd_in_range ? mem_q[rd_word[IDX_W-1:0]] : '0;
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (w_fire) begin
      b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // response held until the master takes it.
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
      if (w_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  assign r_o = '{valid: r_valid_q, data: r_data_q, resp: r_resp_q};
  assign b_o = '{valid: b_valid_q, resp: b_resp_q};

endmodule

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
  input  logic             clk,
  input  logic             rst_n_i,
  input  bus_pkg::ar_req_t ifu_ar_i,
  output logic             ifu_ar_ready_o,
  output bus_pkg::r_resp_t ifu_r_o,
  input  logic             ifu_r_ready_i,
  input  bus_pkg::ar_req_t lsu_ar_i,
  output logic             lsu_ar_ready_o,
  output bus_pkg::r_resp_t lsu_r_o,
  input  logic             lsu_r_ready_i,
  input  bus_pkg::w_req_t  lsu_w_i,
  output logic             lsu_w_ready_o,
  output bus_pkg::b_resp_t lsu_b_o,
  input  logic             lsu_b_ready_i
);
  import arb_pkg::*;
  import bus_pkg::*;

  grant_e  grant;
  logic    resp_done;
  ar_req_t slv_ar;
  w_req_t  slv_w;
  r_resp_t slv_r;
  b_resp_t slv_b;
  logic    slv_ar_ready;
  logic    slv_w_ready;
  logic    slv_r_ready;
  logic    slv_b_ready;

  bus_arbiter u_arbiter (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ifu_ar_valid_i (ifu_ar_i.valid),
    .lsu_ar_valid_i (lsu_ar_i.valid),
    .lsu_w_valid_i  (lsu_w_i.valid),
    .resp_done_i    (resp_done),
    .grant_o        (grant)
  );

  bus_mux u_mux (
    .grant_i        (grant),
    .ifu_ar_i       (ifu_ar_i),
    .lsu_ar_i       (lsu_ar_i),
    .lsu_w_i        (lsu_w_i),
    .ifu_r_ready_i  (ifu_r_ready_i),
    .lsu_r_ready_i  (lsu_r_ready_i),
    .lsu_b_ready_i  (lsu_b_ready_i),
    .ifu_ar_ready_o (ifu_ar_ready_o),
    .lsu_ar_ready_o (lsu_ar_ready_o),
    .lsu_w_ready_o  (lsu_w_ready_o),
    .ifu_r_o        (ifu_r_o),
    .lsu_r_o        (lsu_r_o),
    .lsu_b_o        (lsu_b_o),
    .slv_ar_o       (slv_ar),
    .slv_w_o        (slv_w),
    .slv_ar_ready_i (slv_ar_ready),
    .slv_w_ready_i  (slv_w_ready),
    .slv_r_i        (slv_r),
    .slv_b_i        (slv_b),
    .slv_r_ready_o  (slv_r_ready),
    .slv_b_ready_o  (slv_b_ready),
    .resp_done_o    (resp_done)
  );

  sram_slave u_sram (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ar_i       (slv_ar),
    .ar_ready_o (slv_ar_ready),
    .r_o        (slv_r),
    .r_ready_i  (slv_r_ready),
    .w_i        (slv_w),
    .w_ready_o  (slv_w_ready),
    .b_o        (slv_b),
    .b_ready_i  (slv_b_ready)
  );

endmodule

// ==== bench/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_subsystem_tb;
  import bus_pkg::*;
  import arb_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int IDX_W   = $clog2(`MEM_DEPTH);
  localparam int OFS_W   = $clog2(`MEM_STRB_W);
  localparam int HALF    = `MEM_DEPTH / 2;
  localparam int ROUNDS  = 300;

  logic                   clk;
  logic                   rst_n_i;
  ar_req_t                ifu_ar;
  ar_req_t                lsu_ar;
  w_req_t                 lsu_w;
  logic                   ifu_r_ready;
  logic                   lsu_r_ready;
  logic                   lsu_b_ready;
  logic                   ifu_ar_ready_o;
  logic                   lsu_ar_ready_o;
  logic                   lsu_w_ready_o;
  r_resp_t                ifu_r_o;
  r_resp_t                lsu_r_o;
  b_resp_t                lsu_b_o;
  logic [`MEM_DATA_W-1:0] ref_mem [`MEM_DEPTH];
  logic                   ifu_busy;
  logic                   lsu_rd_busy;
  logic                   lsu_wr_busy;
  int                     seed;
  int                     errors;
  int                     checks;
  int                     fetches;
  int                     lsu_ops;

  mem_subsystem UUT (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ifu_ar_i       (ifu_ar),
    .ifu_ar_ready_o (ifu_ar_ready_o),
    .ifu_r_o        (ifu_r_o),
    .ifu_r_ready_i  (ifu_r_ready),
    .lsu_ar_i       (lsu_ar),
    .lsu_ar_ready_o (lsu_ar_ready_o),
    .lsu_r_o        (lsu_r_o),
    .lsu_r_ready_i  (lsu_r_ready),
    .lsu_w_i        (lsu_w),
    .lsu_w_ready_o  (lsu_w_ready_o),
    .lsu_b_o        (lsu_b_o),
    .lsu_b_ready_i  (lsu_b_ready)
  );

  always #5 clk = ~clk;

  // reference memory model indexed by word.
  function automatic r_resp_t model_read(input logic [`MEM_ADDR_W-1:0] addr);
    r_resp_t                exp;
    logic [`MEM_ADDR_W-1:0] idx;
    idx       = addr >> OFS_W;
    exp.valid = 1'b1;
    exp.data  = '0;
    exp.resp  = RESP_SLVERR;
    if (idx < `MEM_DEPTH) begin
      exp.data = ref_mem[idx[IDX_W-1:0]];
      exp.resp = RESP_OKAY;
    end
    return exp;
  endfunction

  function automatic b_resp_t model_write(input logic [`MEM_ADDR_W-1:0] addr,
                                          input logic [`MEM_DATA_W-1:0] data,
                                          input logic [`MEM_STRB_W-1:0] strb);
    b_resp_t                exp;
    logic [`MEM_ADDR_W-1:0] idx;
    idx       = addr >> OFS_W;
    exp.valid = 1'b1;
    exp.resp  = RESP_SLVERR;
    if (idx < `MEM_DEPTH) begin
      exp.resp = RESP_OKAY;
      for (int b = 0; b < `MEM_STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[idx[IDX_W-1:0]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    return exp;
  endfunction

  task automatic check_rdata(input r_resp_t got, input r_resp_t exp, input string what);
    checks++;
    if (got.data !== exp.data || got.resp !== exp.resp) begin
      errors++;
      $display("FAILED at %0t: %s got %h %s, expected %h %s", $time, what,
               got.data, got.resp.name(), exp.data, exp.resp.name());
    end
  endtask

  task automatic check_bresp(input b_resp_t got, input b_resp_t exp, input string what);
    checks++;
    if (got.resp !== exp.resp) begin
      errors++;
      $display("FAILED at %0t: %s got %s, expected %s", $time, what,
               got.resp.name(), exp.resp.name());
    end
  endtask

  task automatic report_hang(input string chan);
    $display("timeout: no handshake on the %s channel after %0d cycles", chan, TIMEOUT);
    $display("Done: errors found");
    $finish;
  endtask

  // called on a rising edge so a new request follows the last response at once.
  task automatic fetch_word(input logic [`MEM_ADDR_W-1:0] addr);
    r_resp_t exp;
    r_resp_t got;
    int      t;
    int      hold;
    ifu_busy = 1'b1;
    exp      = model_read(addr);
    ifu_ar <= '{valid: 1'b1, addr: addr};
    t = 0;
    @(negedge clk);
    while (!ifu_ar_ready_o) begin
      t++;
      if (t > TIMEOUT) begin
        report_hang("instruction read address");
      end
      @(negedge clk);
    end
    @(posedge clk);
    ifu_ar <= '0;
    // back-pressure on the response.
    hold = $unsigned($random(seed)) % 4;
    repeat (hold) @(posedge clk);
    ifu_r_ready <= 1'b1;
    t = 0;
    @(negedge clk);
    while (!ifu_r_o.valid) begin
      t++;
      if (t > TIMEOUT) begin
        report_hang("instruction read data");
      end
      @(negedge clk);
    end
    got = ifu_r_o;
    @(posedge clk);
    ifu_r_ready <= 1'b0;
    ifu_busy = 1'b0;
    check_rdata(got, exp, "fetch");
    fetches++;
  endtask

  task automatic load_word(input logic [`MEM_ADDR_W-1:0] addr);
    r_resp_t exp;
    r_resp_t got;
    int      t;
    int      hold;
    lsu_rd_busy = 1'b1;
    exp         = model_read(addr);
    lsu_ar <= '{valid: 1'b1, addr: addr};
    t = 0;
    @(negedge clk);
    while (!lsu_ar_ready_o) begin
      t++;
      if (t > TIMEOUT) begin
        report_hang("load read address");
      end
      @(negedge clk);
    end
    @(posedge clk);
    lsu_ar <= '0;
    hold = $unsigned($random(seed)) % 4;
    repeat (hold) @(posedge clk);
    lsu_r_ready <= 1'b1;
    t = 0;
    @(negedge clk);
    while (!lsu_r_o.valid) begin
      t++;
      if (t > TIMEOUT) begin
        report_hang("load read data");
      end
      @(negedge clk);
    end
    got = lsu_r_o;
    @(posedge clk);
    lsu_r_ready <= 1'b0;
    lsu_rd_busy = 1'b0;
    check_rdata(got, exp, "load");
    lsu_ops++;
  endtask

  task automatic store_word(input logic [`MEM_ADDR_W-1:0] addr,
                            input logic [`MEM_DATA_W-1:0] data,
                            input logic [`MEM_STRB_W-1:0] strb);
    b_resp_t exp;
    b_resp_t got;
    int      t;
    int      hold;
    lsu_wr_busy = 1'b1;
    lsu_w <= '{valid: 1'b1, addr: addr, data: data, strb: strb};
    t = 0;
    @(negedge clk);
    while (!lsu_w_ready_o) begin
      t++;
      if (t > TIMEOUT) begin
        report_hang("store request");
      end
      @(negedge clk);
    end
    @(posedge clk);
    lsu_w <= '0;
    exp  = model_write(addr, data, strb);
    hold = $unsigned($random(seed)) % 4;
    repeat (hold) @(posedge clk);
    lsu_b_ready <= 1'b1;
    t = 0;
    @(negedge clk);
    while (!lsu_b_o.valid) begin
      t++;
      if (t > TIMEOUT) begin
        report_hang("store response");
      end
      @(negedge clk);
    end
    got = lsu_b_o;
    @(posedge clk);
    lsu_b_ready <= 1'b0;
    lsu_wr_busy = 1'b0;
    check_bresp(got, exp, "store");
    lsu_ops++;
  endtask

  // a response must only reach the master that asked.
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (ifu_r_o.valid && !ifu_busy) begin
        errors++;
        $display("FAILED at %0t: read data on the ifu port with no fetch pending", $time);
      end
      if (lsu_r_o.valid && !lsu_rd_busy) begin
        errors++;
        $display("FAILED at %0t: read data on the lsu port with no load pending", $time);
      end
      if (lsu_b_o.valid && !lsu_wr_busy) begin
        errors++;
        $display("FAILED at %0t: write response with no store pending", $time);
      end
    end
  end

  initial begin
    logic [`MEM_ADDR_W-1:0] idx;
    seed        = 86;
    errors      = 0;
    checks      = 0;
    fetches     = 0;
    lsu_ops     = 0;
    ifu_busy    = 1'b0;
    lsu_rd_busy = 1'b0;
    lsu_wr_busy = 1'b0;
    clk         = 1'b0;
    rst_n_i     <= 1'b0;
    ifu_ar      <= '0;
    lsu_ar      <= '0;
    lsu_w       <= '0;
    ifu_r_ready <= 1'b0;
    lsu_r_ready <= 1'b0;
    lsu_b_ready <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;

    repeat (4) begin
      @(negedge clk);
      if (ifu_ar_ready_o || lsu_ar_ready_o || lsu_w_ready_o ||
          ifu_r_o.valid || lsu_r_o.valid || lsu_b_o.valid) begin
        errors++;
        $display("FAILED at %0t: ready or response valid high with no request", $time);
      end
    end
    @(posedge clk);

    // fill every word, then read it all back.
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      store_word(32'(i) << OFS_W, $random(seed), '1);
    end
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      load_word(32'(i) << OFS_W);
    end

    // partial strobes.
    repeat (64) begin
      idx = $unsigned($random(seed)) % `MEM_DEPTH;
      store_word(idx << OFS_W, $random(seed), 4'($random(seed)));
      load_word(idx << OFS_W);
    end

    // out of range stores must leave the aliased word intact.
    repeat (8) begin
      idx = `MEM_DEPTH + $unsigned($random(seed)) % 1024;
      store_word(idx << OFS_W, $random(seed), '1);
      load_word(idx << OFS_W);
      load_word((idx % `MEM_DEPTH) << OFS_W);
    end

    // fetches in the low half race data traffic in the high half.
    fork
      begin
        repeat (ROUNDS) begin
          fetch_word(($unsigned($random(seed)) % HALF) << OFS_W);
        end
      end
      begin
        repeat (ROUNDS) begin
          if ($random(seed) & 1) begin
            store_word((HALF + $unsigned($random(seed)) % HALF) << OFS_W,
                       $random(seed), 4'($random(seed)));
          end else begin
            load_word((HALF + $unsigned($random(seed)) % HALF) << OFS_W);
          end
        end
      end
    join

    $display("checks %0d, errors %0d, fetches %0d, lsu ops %0d",
             checks, errors, fetches, lsu_ops);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== mem_subsystem.f ====
+incdir+source
source/bus_pkg.sv
source/arb_pkg.sv
source/bus_arbiter.sv
source/bus_mux.sv
source/sram_slave.sv
source/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// ==== Makefile ====
# Verilator simulation of the memory subsystem.
# sim passes only when the log holds the pass line.

sim:
	verilator --binary --timing -j 0 --top-module mem_subsystem_tb \
	  -Mdir obj_dir -f mem_subsystem.f
	./obj_dir/Vmem_subsystem_tb | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
